// ==== bench/vga_fb_asserts.sv ====
// wishbone protocol checks for the fetch unit
// bound into every wb_fetch instance, classic single reads only
`timescale 1ns/1ps
`default_nettype none

module vga_fb_asserts (
    input logic        clk,
    input logic        arst_n,
    input logic        CYC_O,
    input logic        STB_O,
    input logic [31:0] ADR_O,
    input logic        ACK_I
);

    // single read, strobe and cycle move together
    stb_with_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        STB_O == CYC_O)
        else $error("STB_O differs from CYC_O");

    // address held while waiting for ack
    adr_held: assert property (@(posedge clk) disable iff (!arst_n)
        (CYC_O && !ACK_I) |=> (CYC_O && $stable(ADR_O)))
        else $error("ADR_O changed or CYC_O dropped before ack");

    // cycle ends on the ack edge
    cyc_ends_on_ack: assert property (@(posedge clk) disable iff (!arst_n)
        (CYC_O && ACK_I) |=> !CYC_O)
        else $error("CYC_O still high in the cycle after ack");

    // bus idle once reset has been seen
    idle_in_reset: assert property (@(posedge clk)
        !arst_n |=> (!CYC_O && !STB_O))
        else $error("bus active during reset");

endmodule

bind wb_fetch vga_fb_asserts i_vga_fb_asserts (
    .clk    (clk),
    .arst_n (arst_n),
    .CYC_O  (CYC_O),
    .STB_O  (STB_O),
    .ADR_O  (ADR_O),
    .ACK_I  (ACK_I)
);

`default_nettype wire

// ==== bench/vga_fb_tb.sv ====
// directed testbench for the framebuffer display engine
// 40 cycle lines, 8 line frames, wishbone memory with adjustable ack delay
`timescale 1ns/1ps
`default_nettype none

module vga_fb_tb;

    localparam logic [31:0] mem_base  = 32'h0000_1000;
    localparam int          line_len  = 40;
    localparam int          frame_len = 320;
    // gpio map of the top level
    localparam int pin_hsync    = 0;
    localparam int pin_vsync    = 1;
    localparam int pin_pixel    = 2;
    localparam int pin_de       = 3;
    localparam int pin_underrun = 4;

    logic          clk = 1'b0;
    logic          arst_n;
    logic          en;
    logic [127:0]  la_data_in;
    logic [127:0]  la_data_out;
    logic [127:0]  la_oenb;
    logic [33:0]   gpio_in;
    logic [33:0]   gpio_out;
    logic [33:0]   gpio_oeb;
    logic [31:0]   mem_adr_start;
    logic [31:0]   ADR_O;
    logic [31:0]   DAT_O;
    logic [3:0]    SEL_O;
    logic          WE_O;
    logic          STB_O;
    logic          CYC_O;
    logic [31:0]   DAT_I;
    logic          ACK_I;

    int            seed = 7;
    logic [31:0]   key;
    int            ack_delay = 2;
    int            ack_cnt;
    logic          cyc_prev = 1'b0;
    // byte address of every bus cycle in issue order
    logic [31:0]   adr_log [$];

    vga_fb_top #(
        .h_active (32),
        .h_front  (2),
        .h_sync   (4),
        .h_back   (2),
        .v_active (4),
        .v_front  (1),
        .v_sync   (2),
        .v_back   (1)
    ) i_vga_fb_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .en            (en),
        .la_data_in    (la_data_in),
        .la_data_out   (la_data_out),
        .la_oenb       (la_oenb),
        .gpio_in       (gpio_in),
        .gpio_out      (gpio_out),
        .gpio_oeb      (gpio_oeb),
        .mem_adr_start (mem_adr_start),
        .ADR_O         (ADR_O),
        .DAT_O         (DAT_O),
        .SEL_O         (SEL_O),
        .WE_O          (WE_O),
        .STB_O         (STB_O),
        .CYC_O         (CYC_O),
        .DAT_I         (DAT_I),
        .ACK_I         (ACK_I)
    );

    always #20 clk = ~clk;

    // memory contents mix in every address bit
    function automatic logic [31:0] scramble(input logic [31:0] adr);
        logic [31:0] x;
        x = (adr ^ key) * 32'h9e37_79b1;
        return x ^ (x >> 15);
    endfunction

    function automatic logic pin_level(input int pin);
        logic [33:0] v;
        v = gpio_out >> pin;
        return v[0];
    endfunction

    // memory model acks after ack_delay wait cycles
    initial begin
        ACK_I   <= 1'b0;
        DAT_I   <= '0;
        ack_cnt = 0;
        forever begin
            @(posedge clk);
            if (!arst_n) begin
                ACK_I   <= 1'b0;
                ack_cnt = 0;
            end else if (CYC_O && STB_O && !ACK_I) begin
                if (ack_cnt >= ack_delay) begin
                    ACK_I   <= 1'b1;
                    DAT_I   <= scramble(ADR_O);
                    ack_cnt = 0;
                end else begin
                    ack_cnt = ack_cnt + 1;
                end
            end else begin
                ACK_I <= 1'b0;
            end
        end
    end

    // log the address at the start of each bus cycle
    always @(posedge clk) begin
        if (CYC_O && !cyc_prev) begin
            adr_log.push_back(ADR_O);
        end
        cyc_prev = CYC_O;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp,
                            input string name);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s is %0h, expected %0h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic wait_pin(input int pin, input logic level, input int limit,
                            input string what);
        int t = 0;
        @(negedge clk);
        while (pin_level(pin) !== level) begin
            if (t == limit) begin
                stop_on_error($sformatf("timed out waiting for %s", what));
            end
            t++;
            @(negedge clk);
        end
    endtask

    // counts samples at the given level over a window starting now
    task automatic count_level(input int pin, input logic level, input int cycles,
                               output int n);
        n = 0;
        for (int i = 0; i < cycles; i++) begin
            if (pin_level(pin) === level) begin
                n++;
            end
            @(negedge clk);
        end
    endtask

    // also watches WE_O, SEL_O and DAT_O every cycle
    task automatic collect_reads(input int count, input int limit);
        int t = 0;
        while (adr_log.size() < count) begin
            check_eq(64'(WE_O), 64'd0, "WE_O");
            check_eq(64'(SEL_O), 64'hf, "SEL_O");
            check_eq(64'(DAT_O), 64'd0, "DAT_O");
            if (t == limit) begin
                stop_on_error("timed out waiting for bus reads");
            end
            t++;
            @(negedge clk);
        end
    endtask

    task automatic expect_idle_outputs();
        check_eq(64'(CYC_O), 64'd0, "CYC_O");
        check_eq(64'(STB_O), 64'd0, "STB_O");
        check_eq(64'(gpio_out[1:0]), 64'h3, "gpio_out[1:0]");
        check_eq(64'(gpio_out[4:2]), 64'h0, "gpio_out[4:2]");
        check_eq(64'(gpio_out[33:5]), 64'h0, "gpio_out[33:5]");
        check_eq(64'(gpio_oeb), 64'h3_ffff_ffe0, "gpio_oeb");
        check_eq(64'(la_data_out[127:64]), 64'd0, "la_data_out[127:64]");
        check_eq(64'(la_data_out[63:0]), 64'd0, "la_data_out[63:0]");
    endtask

    task automatic apply_reset();
        @(negedge clk);
        expect_idle_outputs();
        // second rising edge under reset before release
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        expect_idle_outputs();
    endtask

    task automatic measure_sync_timing();
        int n;
        wait_pin(pin_hsync, 1'b1, 2 * line_len, "hsync_n high");
        wait_pin(pin_hsync, 1'b0, 2 * line_len, "hsync_n to fall");
        count_level(pin_hsync, 1'b0, line_len, n);
        check_eq(64'(n), 64'd4, "hsync_n low cycles");
        // next pulse one line later
        check_eq(64'(pin_level(pin_hsync)), 64'd0, "hsync_n period");
        wait_pin(pin_de, 1'b0, 2 * frame_len, "de low");
        wait_pin(pin_de, 1'b1, 2 * frame_len, "de to rise");
        count_level(pin_de, 1'b1, line_len, n);
        check_eq(64'(n), 64'd32, "de high cycles");
        wait_pin(pin_vsync, 1'b1, 2 * frame_len, "vsync_n high");
        wait_pin(pin_vsync, 1'b0, 2 * frame_len, "vsync_n to fall");
        count_level(pin_vsync, 1'b0, frame_len, n);
        check_eq(64'(n), 64'(2 * line_len), "vsync_n low cycles");
        check_eq(64'(pin_level(pin_vsync)), 64'd0, "vsync_n period");
    endtask

    task automatic follow_frame_addresses();
        int mark;
        wait_pin(pin_vsync, 1'b1, 2 * frame_len, "vsync_n high");
        wait_pin(pin_vsync, 1'b0, 2 * frame_len, "vsync_n to fall");
        // words 0 and 1 of the coming frame already buffered
        mark = adr_log.size();
        collect_reads(mark + 8, 3 * frame_len);
        for (int i = 0; i < 8; i++) begin
            check_eq(64'(adr_log[mark + i]), 64'(mem_base + 32'(((i + 2) % 4) * 4)),
                     "ADR_O");
        end
    endtask

    task automatic compare_pixels();
        logic [31:0] word;
        int n = 0;
        int t = 0;
        ack_delay = 2;
        wait_pin(pin_vsync, 1'b1, 2 * frame_len, "vsync_n high");
        wait_pin(pin_vsync, 1'b0, 2 * frame_len, "vsync_n to fall");
        while (n < 128) begin
            if (pin_level(pin_de)) begin
                // pixel n is bit n mod 32 of word n / 32
                word = scramble(mem_base + 32'((n / 32) * 4)) >> (n % 32);
                check_eq(64'(pin_level(pin_pixel)), 64'(word[0]), "pixel");
                n++;
            end
            check_eq(64'(pin_level(pin_underrun)), 64'd0, "underrun");
            if (t == 2 * frame_len) begin
                stop_on_error("timed out collecting visible pixels");
            end
            t++;
            @(negedge clk);
        end
    endtask

    task automatic toggle_enable();
        int mark;
        int t = 0;
        @(posedge clk);
        en <= 1'b0;
        // open read still completes
        @(negedge clk);
        while (CYC_O) begin
            if (t == 100) begin
                stop_on_error("timed out waiting for the open bus cycle to end");
            end
            t++;
            @(negedge clk);
        end
        // timing register and output register drain
        repeat (2) @(negedge clk);
        mark = adr_log.size();
        for (int i = 0; i < frame_len; i++) begin
            check_eq(64'(CYC_O), 64'd0, "CYC_O");
            check_eq(64'(pin_level(pin_de)), 64'd0, "de");
            @(negedge clk);
        end
        @(posedge clk);
        en <= 1'b1;
        collect_reads(mark + 4, 3 * frame_len);
        for (int i = 0; i < 4; i++) begin
            check_eq(64'(adr_log[mark + i]), 64'(mem_base + 32'(i * 4)), "ADR_O");
        end
    endtask

    task automatic starve_fetches();
        ack_delay = 60;
        wait_pin(pin_underrun, 1'b1, 4 * frame_len, "underrun to rise");
        // starved on a visible pixel
        check_eq(64'(pin_level(pin_de)), 64'd1, "de at underrun");
        ack_delay = 2;
        for (int i = 0; i < 2 * frame_len; i++) begin
            @(negedge clk);
            check_eq(64'(pin_level(pin_underrun)), 64'd1, "underrun");
        end
        @(posedge clk);
        arst_n <= 1'b0;
        @(negedge clk);
        check_eq(64'(pin_level(pin_underrun)), 64'd0, "underrun after reset");
    endtask

    initial begin
        key = $random(seed);
        arst_n        <= 1'b0;
        en            <= 1'b1;
        la_data_in    <= '0;
        la_oenb       <= '1;
        gpio_in       <= '0;
        mem_adr_start <= mem_base;
        apply_reset();
        measure_sync_timing();
        follow_frame_addresses();
        compare_pixels();
        toggle_enable();
        starve_fetches();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the framebuffer testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    -f vga_fb.f \
    --top-module vga_fb_tb \
    -Mdir "$build_dir"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/Vvga_fb_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -qx "PASS: all tests" "$log_file"
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed, pass line not found in $log_file"
    exit 1
fi

echo "simulation passed"
exit 0

// ==== src/pixel_buffer.sv ====
// pixel buffer
// two word prefetch slots fed by the fetch unit, shifts one pixel per
// visible clock LSB first and flags a sticky underrun when starved
`timescale 1ns/1ps
`default_nettype none

module pixel_buffer #(
    // words in one visible frame
    parameter int frame_words = 9600
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     en,
    input  vga_fb_pkg::vga_timing_t  timing,
    input  logic                     fetch_busy,
    input  vga_fb_pkg::fetch_rsp_t   rsp,
    output vga_fb_pkg::fetch_req_t   req,
    output logic                     hsync_n,
    output logic                     vsync_n,
    output logic                     de,
    output logic                     pixel,
    output logic                     underrun
);

    localparam int pos_w = $clog2(vga_fb_pkg::word_w);
    localparam logic [pos_w-1:0] last_pos = pos_w'(vga_fb_pkg::word_w - 1);
    localparam logic [vga_fb_pkg::idx_w-1:0] words_per_frame =
        frame_words[vga_fb_pkg::idx_w-1:0];

    vga_fb_pkg::pixel_word_t         slot_data [2];
    logic [1:0]                      slot_full;
    logic                            rd_sel;
    logic                            wr_sel;
    logic [pos_w-1:0]                bit_pos;
    logic [vga_fb_pkg::idx_w-1:0]    index;
    logic                            pending;
    logic                            discard;
    logic                            synced;
    logic                            flush;
    logic                            accept;
    logic                            show;
    logic                            req_ok;

    // restart point, new frame or display disabled
    assign flush  = timing.frame_start || !en;
    // response that belongs to the current frame
    assign accept = rsp.valid && !discard && !flush;
    // visible pixel once aligned to a frame boundary
    assign show   = synced && en && timing.de;

    // one fetch in flight, stop at the frame's last word
    assign req_ok = synced && !flush && !fetch_busy && !pending &&
                    (slot_full != 2'b11) && (index < words_per_frame);

    assign req.valid = req_ok;
    assign req.index = index;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_full <= 2'b00;
            rd_sel    <= 1'b0;
            wr_sel    <= 1'b0;
            bit_pos   <= '0;
            index     <= '0;
            pending   <= 1'b0;
            discard   <= 1'b0;
            synced    <= 1'b0;
        end else begin
            // outstanding fetch tracking, bus cycle always completes
            if (req_ok) begin
                pending <= 1'b1;
            end else if (rsp.valid) begin
                pending <= 1'b0;
            end
            if (flush) begin
                slot_full <= 2'b00;
                rd_sel    <= 1'b0;
                wr_sel    <= 1'b0;
                bit_pos   <= '0;
                index     <= '0;
                // word still on the bus is stale
                discard   <= pending && !rsp.valid;
                // first blanking after enable aligns the buffer
                synced    <= en;
            end else begin
                if (rsp.valid) begin
                    discard <= 1'b0;
                end
                if (req_ok) begin
                    index <= index + 1'b1;
                end
                // slot written and slot drained are never the same one
                if (accept) begin
                    slot_full[wr_sel] <= 1'b1;
                    wr_sel            <= !wr_sel;
                end
                if (show && slot_full[rd_sel]) begin
                    bit_pos <= bit_pos + 1'b1;
                    if (bit_pos == last_pos) begin
                        slot_full[rd_sel] <= 1'b0;
                        rd_sel            <= !rd_sel;
                    end
                end
            end
        end
    end

    // slot storage
    always_ff @(posedge clk) begin
        if (accept) begin
            slot_data[wr_sel] <= rsp.data;
        end
    end

    // outputs lag the timing struct by one cycle, all aligned
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hsync_n  <= 1'b1;
            vsync_n  <= 1'b1;
            de       <= 1'b0;
            pixel    <= 1'b0;
            underrun <= 1'b0;
        end else begin
            hsync_n <= timing.hsync_n;
            vsync_n <= timing.vsync_n;
            de      <= timing.de;
            // starved pixels show black
            pixel   <= show && slot_full[rd_sel] && slot_data[rd_sel][bit_pos];
            // sticky, only reset clears it
            if (show && !slot_full[rd_sel] && !flush) begin
                underrun <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/vga_fb_pkg.sv ====
// vga framebuffer shared definitions
// word and index widths, pixel word type, and the structs that carry
// timing strobes and fetch traffic between the blocks
`default_nettype none

package vga_fb_pkg;

    // one bus word holds this many monochrome pixels
    localparam int word_w = 32;

    // word index into the framebuffer
    localparam int idx_w = 16;

    // bit 0 is the leftmost pixel on screen
    typedef logic [word_w-1:0] pixel_word_t;

    // registered strobes from the timing generator
    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
        // high on visible pixels
        logic de;
        // single cycle, first cycle of vertical blanking
        logic frame_start;
    } vga_timing_t;

    // word request from the pixel buffer
    typedef struct packed {
        logic             valid;
        logic [idx_w-1:0] index;
    } fetch_req_t;

    // fetched word, valid for one cycle
    typedef struct packed {
        logic        valid;
        pixel_word_t data;
    } fetch_rsp_t;

endpackage

`default_nettype wire

// ==== src/vga_fb_top.sv ====
// monochrome framebuffer display engine, chip level
// joins timing generator, wishbone fetch unit and pixel buffer, gated
// by en, results on gpio 0 to 4
`timescale 1ns/1ps
`default_nettype none

module vga_fb_top #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          en,
    input  logic [127:0]  la_data_in,
    output logic [127:0]  la_data_out,
    input  logic [127:0]  la_oenb,
    input  logic [33:0]   gpio_in,
    output logic [33:0]   gpio_out,
    output logic [33:0]   gpio_oeb,
    input  logic [31:0]   mem_adr_start,
    output logic [31:0]   ADR_O,
    output logic [31:0]   DAT_O,
    output logic [3:0]    SEL_O,
    output logic          WE_O,
    output logic          STB_O,
    output logic          CYC_O,
    input  logic [31:0]   DAT_I,
    input  logic          ACK_I
);

    // visible pixels per frame packed into bus words
    localparam int frame_words = (h_active * v_active) / vga_fb_pkg::word_w;

    vga_fb_pkg::vga_timing_t  timing;
    vga_fb_pkg::fetch_req_t   req;
    vga_fb_pkg::fetch_rsp_t   rsp;
    logic                     fetch_busy;
    logic                     hsync_n;
    logic                     vsync_n;
    logic                     de;
    logic                     pixel;
    logic                     underrun;

    vga_timing #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) i_vga_timing (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (en),
        .timing (timing)
    );

    wb_fetch i_wb_fetch (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_adr_start (mem_adr_start),
        .req           (req),
        .rsp           (rsp),
        .fetch_busy    (fetch_busy),
        .ADR_O         (ADR_O),
        .DAT_O         (DAT_O),
        .SEL_O         (SEL_O),
        .WE_O          (WE_O),
        .STB_O         (STB_O),
        .CYC_O         (CYC_O),
        .DAT_I         (DAT_I),
        .ACK_I         (ACK_I)
    );

    pixel_buffer #(
        .frame_words (frame_words)
    ) i_pixel_buffer (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (en),
        .timing     (timing),
        .fetch_busy (fetch_busy),
        .rsp        (rsp),
        .req        (req),
        .hsync_n    (hsync_n),
        .vsync_n    (vsync_n),
        .de         (de),
        .pixel      (pixel),
        .underrun   (underrun)
    );

    // pins 0 to 4 driven, the rest left as inputs
    assign gpio_out    = {29'b0, underrun, de, pixel, vsync_n, hsync_n};
    assign gpio_oeb    = {{29{1'b1}}, 5'b0};
    assign la_data_out = '0;

endmodule

`default_nettype wire

// ==== src/vga_timing.sv ====
// vga timing generator
// horizontal and vertical counters with registered sync, display enable
// and frame start strobes, counters parked at zero while disabled
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     en,
    output vga_fb_pkg::vga_timing_t  timing
);

    // line length in pixels, frame length in lines
    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;
    localparam int h_w     = $clog2(h_total);
    localparam int v_w     = $clog2(v_total);

    // boundaries at counter width
    localparam logic [h_w-1:0] h_act_end  = h_w'(h_active);
    localparam logic [h_w-1:0] h_sync_beg = h_w'(h_active + h_front);
    localparam logic [h_w-1:0] h_sync_end = h_w'(h_active + h_front + h_sync);
    localparam logic [h_w-1:0] h_last     = h_w'(h_total - 1);
    localparam logic [v_w-1:0] v_act_end  = v_w'(v_active);
    localparam logic [v_w-1:0] v_sync_beg = v_w'(v_active + v_front);
    localparam logic [v_w-1:0] v_sync_end = v_w'(v_active + v_front + v_sync);
    localparam logic [v_w-1:0] v_last     = v_w'(v_total - 1);

    // strobes while idle or in reset
    localparam vga_fb_pkg::vga_timing_t timing_idle = '{
        hsync_n:     1'b1,
        vsync_n:     1'b1,
        de:          1'b0,
        frame_start: 1'b0
    };

    logic [h_w-1:0]           h_cnt;
    logic [v_w-1:0]           v_cnt;
    vga_fb_pkg::vga_timing_t  timing_nxt;

    // position counters, zero is first active pixel of line 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!en) begin
            // hold the after-reset position
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_last) begin
            h_cnt <= '0;
            // end of line, step the line counter
            if (v_cnt == v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // decode strobes from the current position
    always_comb begin
        timing_nxt.de          = (h_cnt < h_act_end) && (v_cnt < v_act_end);
        timing_nxt.hsync_n     = !((h_cnt >= h_sync_beg) && (h_cnt < h_sync_end));
        timing_nxt.vsync_n     = !((v_cnt >= v_sync_beg) && (v_cnt < v_sync_end));
        // first blanking line, first cycle
        timing_nxt.frame_start = (v_cnt == v_act_end) && (h_cnt == '0);
    end

    // registered outputs, one cycle behind the counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            timing <= timing_idle;
        end else if (!en) begin
            timing <= timing_idle;
        end else begin
            timing <= timing_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== src/wb_fetch.sv ====
// wishbone fetch unit
// classic single read master, turns one word index request into one
// bus read and hands the word back as a single cycle response
`timescale 1ns/1ps
`default_nettype none

module wb_fetch (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [31:0]              mem_adr_start,
    input  vga_fb_pkg::fetch_req_t   req,
    output vga_fb_pkg::fetch_rsp_t   rsp,
    output logic                     fetch_busy,
    output logic [31:0]              ADR_O,
    output logic [31:0]              DAT_O,
    output logic [3:0]               SEL_O,
    output logic                     WE_O,
    output logic                     STB_O,
    output logic                     CYC_O,
    input  logic [31:0]              DAT_I,
    input  logic                     ACK_I
);

    typedef enum logic {
        st_idle,
        st_read
    } state_t;

    state_t                   state;
    logic [31:0]              adr_q;
    logic                     rsp_valid;
    vga_fb_pkg::pixel_word_t  rsp_data;

    // idle waits for a request, read holds the cycle until ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (req.valid) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    // cyc and stb drop on the ack edge
                    if (ACK_I) begin
                        state     <= st_idle;
                        rsp_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // byte address of the word, held for the whole cycle
    always_ff @(posedge clk) begin
        if (state == st_idle && req.valid) begin
            adr_q <= mem_adr_start + (32'(req.index) << 2);
        end
    end

    // capture read data on ack
    always_ff @(posedge clk) begin
        if (state == st_read && ACK_I) begin
            rsp_data <= DAT_I;
        end
    end

    assign rsp.valid  = rsp_valid;
    assign rsp.data   = rsp_data;
    assign fetch_busy = (state == st_read);

    // read only, full word lanes
    assign ADR_O = adr_q;
    assign DAT_O = '0;
    assign SEL_O = 4'hf;
    assign WE_O  = 1'b0;
    assign STB_O = (state == st_read);
    assign CYC_O = (state == st_read);

endmodule

`default_nettype wire

// ==== vga_fb.f ====
src/vga_fb_pkg.sv
src/vga_timing.sv
src/wb_fetch.sv
src/pixel_buffer.sv
src/vga_fb_top.sv
bench/vga_fb_asserts.sv
bench/vga_fb_tb.sv
